//--- include/ecc_mem_settings.svh
`ifndef ECC_MEM_SETTINGS_SVH
`define ECC_MEM_SETTINGS_SVH

// ******************************
// memory geometry
// ******************************
`define ECC_ADDR_WIDTH 6                          // word address bits
`define ECC_DEPTH (1 << `ECC_ADDR_WIDTH)          // number of code words

// ******************************
// alarm statistics
// ******************************
`define ECC_ERR_COUNT_WIDTH 8                     // saturating alarm counter

`endif

//--- src/ecc_mem_pkg.sv
`include "ecc_mem_settings.svh"

package ecc_mem_pkg;

    typedef logic [31:0] data_t;                     // user data word
    typedef logic [37:0] code_t;                     // data plus six check bits
    typedef logic [5:0]  syndrome_t;                 // value names the flipped position
    typedef logic [`ECC_ADDR_WIDTH-1:0] addr_t;

    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } mem_op_e;

    // check bit k covers every data position (1-based) with bit k set
    function automatic syndrome_t calc_check(input code_t code);
        syndrome_t chk;
        chk = '0;
        for (int pos = 1; pos <= 38; pos++) begin
            if ((pos & (pos - 1)) != 0) begin        // powers of two hold check bits
                for (int k = 0; k < 6; k++) begin
                    if (pos[k]) begin
                        chk[k] ^= code[pos-1];
                    end
                end
            end
        end
        return chk;
    endfunction

endpackage

//--- src/ecc_mem_if.sv
interface ecc_mem_if (
    input logic clk
);
    import ecc_mem_pkg::*;

    mem_op_e op;                                     // registered request
    addr_t   addr;
    code_t   wr_code;                                // encoded write word, mask applied
    code_t   rd_code;                                // raw word out of the array
    logic    rd_valid;

    modport request (
        input  clk,
        output op, addr, wr_code
    );

    modport array (
        input  clk,
        input  op, addr, wr_code,
        output rd_code, rd_valid
    );

    modport response (
        input  clk,
        input  rd_code, rd_valid
    );

endinterface

//--- src/ecc_enc32.sv
module ecc_enc32 (
    input  logic               clk,
    input  logic               reset,
    input  logic               we,
    input  logic               re,
    input  ecc_mem_pkg::addr_t addr,
    input  ecc_mem_pkg::data_t wdata,
    input  ecc_mem_pkg::code_t inject_mask,
    ecc_mem_if.request         bus
);
    import ecc_mem_pkg::*;

    code_t     code_raw;                             // data placed, check slots empty
    syndrome_t check;
    code_t     code_full;
    mem_op_e   op_next;

    // ******************************
    // encoding
    // ******************************
    // data fills positions 3..38 skipping the powers of two
    assign code_raw = {wdata[31:26], 1'b0,           // 38..33, p32
                       wdata[25:11], 1'b0,           // 31..17, p16
                       wdata[10:4],  1'b0,           // 15..9, p8
                       wdata[3:1],   1'b0,           // 7..5, p4
                       wdata[0],     2'b00};         // 3, p2, p1

    assign check = calc_check(code_raw);

    always_comb begin
        code_full     = code_raw;
        code_full[0]  = check[0];                    // p1
        code_full[1]  = check[1];                    // p2
        code_full[3]  = check[2];                    // p4
        code_full[7]  = check[3];                    // p8
        code_full[15] = check[4];                    // p16
        code_full[31] = check[5];                    // p32
    end

    // write wins when both strobes are high
    assign op_next = we ? OP_WRITE : (re ? OP_READ : OP_IDLE);

    // ******************************
    // request register
    // ******************************
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.op <= OP_IDLE;
        end else begin
            bus.op <= op_next;
        end
    end

    always_ff @(posedge clk) begin
        bus.addr    <= addr;
        bus.wr_code <= code_full ^ inject_mask;      // mask only matters on a write
    end

endmodule

//--- src/ecc_dec32.sv
module ecc_dec32 (
    input  ecc_mem_pkg::code_t code,
    input  logic               dis,
    output ecc_mem_pkg::data_t data,
    output logic               alarm
);
    import ecc_mem_pkg::*;

    syndrome_t stored;                               // check bits as read
    syndrome_t recalc;                               // check bits from data positions
    syndrome_t syndrome;
    code_t     flip;                                 // one-hot correction vector
    code_t     fixed;

    // ******************************
    // syndrome
    // ******************************
    assign stored = {code[31], code[15], code[7], code[3], code[1], code[0]};
    assign recalc = calc_check(code);

    // forced to zero so the raw word passes through
    assign syndrome = dis ? '0 : (stored ^ recalc);

    // ******************************
    // correction
    // ******************************
    // a syndrome on a check position flips a bit that is dropped below
    always_comb begin
        flip = '0;
        if (syndrome != '0 && syndrome <= 6'd38) begin
            flip[syndrome - 6'd1] = 1'b1;
        end
    end

    assign fixed = code ^ flip;

    // same bit order as the encoder packs them
    assign data = {fixed[37:32],                     // d38..d33
                   fixed[30:16],                     // d31..d17
                   fixed[14:8],                      // d15..d9
                   fixed[6:4],                       // d7..d5
                   fixed[2]};                        // d3

    // any nonzero syndrome, also past position 38
    assign alarm = |syndrome;

endmodule

//--- src/ecc_mem_array.sv
`include "ecc_mem_settings.svh"

module ecc_mem_array (
    input  logic     clk,
    input  logic     reset,
    ecc_mem_if.array bus
);
    import ecc_mem_pkg::*;

    code_t mem [0:`ECC_DEPTH-1];                     // code word storage

    // ******************************
    // single port access
    // ******************************
    always_ff @(posedge clk) begin
        if (bus.op == OP_WRITE) begin
            mem[bus.addr] <= bus.wr_code;
        end
        if (bus.op == OP_READ) begin
            bus.rd_code <= mem[bus.addr];            // registered read
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.rd_valid <= 1'b0;
        end else begin
            bus.rd_valid <= (bus.op == OP_READ);     // one-cycle pulse per read
        end
    end

endmodule

//--- src/ecc_read_stage.sv
`include "ecc_mem_settings.svh"

module ecc_read_stage (
    input  logic                            clk,
    input  logic                            reset,
    ecc_mem_if.response                     bus,
    input  logic                            ecc_disable,
    output ecc_mem_pkg::data_t              rdata,
    output logic                            rvalid,
    output logic                            alarm,
    output logic [`ECC_ERR_COUNT_WIDTH-1:0] err_count
);
    import ecc_mem_pkg::*;

    data_t dec_data;
    logic  dec_alarm;

    ecc_dec32 dec_i (
        .code  (bus.rd_code),
        .dis   (ecc_disable),
        .data  (dec_data),
        .alarm (dec_alarm)
    );

    // ******************************
    // result registers
    // ******************************
    always_ff @(posedge clk) begin
        if (bus.rd_valid) begin
            rdata <= dec_data;                       // corrected word
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid    <= 1'b0;
            alarm     <= 1'b0;
            err_count <= '0;
        end else begin
            rvalid <= bus.rd_valid;
            if (bus.rd_valid) begin
                alarm <= dec_alarm;                  // held until the next read
                if (dec_alarm && err_count != '1) begin
                    err_count <= err_count + 1'b1;   // stops at all ones
                end
            end
        end
    end

endmodule

//--- src/ecc_mem_top.sv
`include "ecc_mem_settings.svh"

module ecc_mem_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            we,
    input  logic                            re,
    input  ecc_mem_pkg::addr_t              addr,
    input  ecc_mem_pkg::data_t              wdata,
    input  ecc_mem_pkg::code_t              inject_mask,
    input  logic                            ecc_disable,
    output ecc_mem_pkg::data_t              rdata,
    output logic                            rvalid,
    output logic                            alarm,
    output logic [`ECC_ERR_COUNT_WIDTH-1:0] err_count
);

    // ******************************
    // datapath links
    // ******************************
    ecc_mem_if bus_i (
        .clk (clk)
    );

    ecc_enc32 enc_i (
        .clk         (clk),
        .reset       (reset),
        .we          (we),
        .re          (re),
        .addr        (addr),
        .wdata       (wdata),
        .inject_mask (inject_mask),
        .bus         (bus_i.request)
    );

    ecc_mem_array array_i (
        .clk   (clk),
        .reset (reset),
        .bus   (bus_i.array)
    );

    ecc_read_stage read_i (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus_i.response),
        .ecc_disable (ecc_disable),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .alarm       (alarm),
        .err_count   (err_count)
    );

endmodule

//--- testbench/tb_ecc_mem.sv
`include "ecc_mem_settings.svh"

module tb_ecc_mem;
    import ecc_mem_pkg::*;

    localparam int clk_period = 40;
    localparam int n_random   = 200;
    localparam int n_sat      = 260;                 // enough alarmed reads to saturate
    localparam int total_ops  = `ECC_DEPTH + 2 * n_random + 2 * 32 + 2 * 6 + 2 * 8 + n_sat + 8;

    logic  clk, reset, we, re, ecc_disable, rvalid, alarm;
    addr_t addr;
    data_t wdata, rdata;
    code_t inject_mask;
    logic [`ECC_ERR_COUNT_WIDTH-1:0] err_count, model_count;

    data_t  model_data [0:`ECC_DEPTH-1];             // reference memory
    code_t  model_mask [0:`ECC_DEPTH-1];             // injected flips per address
    logic   model_dis;
    data_t  exp_data [$];
    logic   exp_alarm [$];
    integer seed;
    int     errors, checks, tests_run, tests_failed, test_start;

    ecc_mem_top dut_i (
        .clk(clk), .reset(reset), .we(we), .re(re), .addr(addr), .wdata(wdata),
        .inject_mask(inject_mask), .ecc_disable(ecc_disable), .rdata(rdata),
        .rvalid(rvalid), .alarm(alarm), .err_count(err_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ******************************
    // reference Hamming model
    // ******************************
    function automatic bit is_check_pos(input int pos);
        return (pos & (pos - 1)) == 0;
    endfunction

    function automatic int data_pos(input int j);   // 1-based position of data bit j
        int n;
        n = 0;
        for (int pos = 1; pos <= 38; pos++) begin
            if (!is_check_pos(pos)) begin
                if (n == j) return pos;
                n++;
            end
        end
        return 0;
    endfunction

    // check bits make the xor of all set positions zero
    function automatic code_t encode_word(input data_t d);
        code_t      c;
        logic [5:0] s;
        int         j;
        c = '0;
        s = '0;
        j = 0;
        for (int pos = 1; pos <= 38; pos++) begin
            if (!is_check_pos(pos)) begin
                c[pos-1] = d[j];
                if (d[j]) s ^= pos[5:0];
                j++;
            end
        end
        for (int k = 0; k < 6; k++) c[(1 << k) - 1] = s[k];
        return c;
    endfunction

    task automatic decode_word(input code_t c, input logic dis, output data_t d, output logic al);
        logic [5:0] s;
        int         j;
        s = '0;
        for (int pos = 1; pos <= 38; pos++) begin
            if (c[pos-1]) s ^= pos[5:0];             // xor of set positions
        end
        if (dis) s = '0;
        if (s != 0 && s <= 38) c[s-1] = ~c[s-1];
        j = 0;
        for (int pos = 1; pos <= 38; pos++) begin
            if (!is_check_pos(pos)) begin
                d[j] = c[pos-1];
                j++;
            end
        end
        al = (s != 0);
    endtask

    function automatic addr_t rand_addr();
        logic [31:0] r;
        r = $random(seed);
        return r[`ECC_ADDR_WIDTH-1:0];
    endfunction

    function automatic data_t rand_data();
        return $random(seed);
    endfunction

    // ******************************
    // stimulus tasks
    // ******************************
    task automatic write_word(input addr_t a, input data_t d, input code_t m);
        @(posedge clk);
        we          <= 1'b1;
        re          <= 1'b0;
        addr        <= a;
        wdata       <= d;
        inject_mask <= m;
        model_data[a] = d;
        model_mask[a] = m;
    endtask

    task automatic read_word(input addr_t a);
        data_t d;
        logic  al;
        @(posedge clk);
        we          <= 1'b0;
        re          <= 1'b1;
        addr        <= a;
        inject_mask <= '0;
        decode_word(encode_word(model_data[a]) ^ model_mask[a], model_dis, d, al);
        exp_data.push_back(d);
        exp_alarm.push_back(al);
    endtask

    task automatic write_and_read(input addr_t a, input data_t d);
        @(posedge clk);
        we          <= 1'b1;
        re          <= 1'b1;
        addr        <= a;
        wdata       <= d;
        inject_mask <= '0;
        model_data[a] = d;                           // only the write takes effect
        model_mask[a] = '0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        we          <= 1'b0;
        re          <= 1'b0;
        inject_mask <= '0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle_cycle();
        while (exp_data.size() != 0 && n < 8) begin
            @(posedge clk);
            n++;
        end
        checks++;
        assert (exp_data.size() == 0) else begin
            $display("%0d read results never arrived, time %0t", exp_data.size(), $time);
            errors++;
        end
    endtask

    task automatic set_disable(input logic v);
        @(posedge clk);
        ecc_disable <= v;
        model_dis = v;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    // ******************************
    // response monitor
    // ******************************
    initial begin : monitor
        data_t d;
        logic  al;
        forever begin
            @(negedge clk);
            if (!reset && rvalid) begin
                checks++;
                assert (exp_data.size() != 0) else begin
                    $display("rvalid pulsed with no read pending, time %0t", $time);
                    errors++;
                end
                if (exp_data.size() != 0) begin
                    d  = exp_data.pop_front();
                    al = exp_alarm.pop_front();
                    if (al && model_count != '1) model_count++;
                    checks += 3;
                    assert (rdata === d) else begin
                        $display("Error at %0t: rdata is %h, expected %h", $time, rdata, d);
                        errors++;
                    end
                    assert (alarm === al) else begin
                        $display("Error at %0t: alarm is %b, expected %b", $time, alarm, al);
                        errors++;
                    end
                    assert (err_count === model_count) else begin
                        $display("Error at %0t: err_count is %0d, expected %0d",
                                 $time, err_count, model_count);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #((total_ops * 4 + 400) * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    // ******************************
    // test sequence
    // ******************************
    initial begin : main
        addr_t       a;
        logic [31:0] r;
        seed = 32'h681d_0926;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        test_start = 0;
        model_dis = 1'b0;
        model_count = '0;
        reset = 1'b1;
        we = 1'b0;
        re = 1'b0;
        addr = '0;
        wdata = '0;
        inject_mask = '0;
        ecc_disable = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        checks += 2;
        assert (err_count === '0) else begin
            $display("Error at %0t: err_count is %0d, expected 0", $time, err_count);
            errors++;
        end
        assert (rvalid === 1'b0) else begin
            $display("Error at %0t: rvalid is %b, expected 0", $time, rvalid);
            errors++;
        end
        finish_test("reset state");

        for (int i = 0; i < `ECC_DEPTH; i++) write_word(addr_t'(i), rand_data(), '0);
        for (int i = 0; i < n_random; i++) begin
            r = $random(seed);
            a = rand_addr();
            case (r[1:0])
                2'd0: write_word(a, rand_data(), '0);
                2'd2: begin
                    write_word(a, rand_data(), '0);  // read right behind the write
                    read_word(a);
                end
                default: read_word(a);
            endcase
        end
        drain();
        finish_test("clean round trip");

        for (int j = 0; j < 32; j++) begin
            a = rand_addr();
            write_word(a, rand_data(), code_t'(1) << (data_pos(j) - 1));
            read_word(a);
        end
        drain();
        finish_test("single data-bit correction");

        for (int k = 0; k < 6; k++) begin
            a = rand_addr();
            write_word(a, rand_data(), code_t'(1) << ((1 << k) - 1));
            read_word(a);
        end
        drain();
        finish_test("check-bit error");

        set_disable(1'b1);
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            a = rand_addr();
            write_word(a, rand_data(), code_t'(1) << (data_pos(r[4:0]) - 1));
            read_word(a);
        end
        drain();
        set_disable(1'b0);
        finish_test("ecc disable");

        a = rand_addr();
        write_word(a, rand_data(), code_t'(1) << (data_pos(7) - 1));
        repeat (n_sat) read_word(a);
        drain();
        checks++;
        assert (err_count === '1) else begin
            $display("Error at %0t: err_count is %0d, expected %0d",
                     $time, err_count, {`ECC_ERR_COUNT_WIDTH{1'b1}});
            errors++;
        end
        finish_test("error counter saturation");

        a = rand_addr();
        write_and_read(a, rand_data());
        drain();
        repeat (4) idle_cycle();                     // a stray rvalid would show up here
        read_word(a);
        drain();
        finish_test("write priority");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- ecc_mem_top.f
+incdir+include
src/ecc_mem_pkg.sv
src/ecc_mem_if.sv
src/ecc_enc32.sv
src/ecc_dec32.sv
src/ecc_mem_array.sv
src/ecc_read_stage.sv
src/ecc_mem_top.sv
testbench/tb_ecc_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the ECC memory testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ecc_mem \
    --Mdir obj_dir -o tb_ecc_mem_sim \
    -f ecc_mem_top.f

./obj_dir/tb_ecc_mem_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
